/* Makefile */
# Verilator build and run of the trigger path testbench

VERILATOR ?= verilator
TOP       ?= tb_trigger_top
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/10ps

SRCS := $(filter %.sv,$(shell cat $(FILELIST)))
HDRS := $(wildcard *.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "Done: no errors" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* all.f */
+incdir+.
trig_pkg.sv
ttc_trigger_receiver.sv
channel_acq_controller.sv
event_fifo.sv
readout_requester.sv
trigger_top.sv
tb_trigger_top.sv

/* channel_acq_controller.sv */
// chan_en is sampled only when a record is taken; dones count only after the trigger pulse
`timescale 1ns/10ps

module channel_acq_controller (
    input  logic                 clk_ttc,
    input  logic                 rst_n,
    input  trig_pkg::trig_rec_t  rec,         // from trigger receiver
    input  logic                 rec_valid,
    output logic                 rec_ready,
    input  trig_pkg::chan_mask_t chan_en,     // enabled channels
    input  trig_pkg::chan_mask_t chan_dones,  // acquisition done pulses
    output trig_pkg::chan_mask_t chan_enable, // held for the whole acquisition
    output trig_pkg::chan_mask_t chan_trig,   // one-cycle trigger per channel
    output trig_pkg::acq_event_t evt,         // to event FIFO
    output logic                 evt_valid,
    input  logic                 evt_ready
);
    import trig_pkg::*;

    acq_state_t state;
    trig_rec_t  rec_q;        // trigger being served
    chan_mask_t mask_q;       // channels fired for it
    chan_mask_t pending;      // fired channels without a done yet
    chan_mask_t pending_next;

    assign pending_next = pending & ~chan_dones; // stray dones on idle bits fall out here

    // ---------------------------------------------------------
    // state machine
    // ---------------------------------------------------------

    always_ff @(posedge clk_ttc or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            pending <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (rec_valid) begin
                        if (chan_en == '0) begin
                            state <= PUSH; // nothing to fire
                        end else begin
                            state <= FIRE;
                        end
                    end
                end
                FIRE: begin
                    pending <= mask_q; // start collecting
                    state   <= WAIT_DONE;
                end
                WAIT_DONE: begin
                    pending <= pending_next;
                    if (pending_next == '0) begin
                        state <= PUSH;
                    end
                end
                PUSH: begin
                    if (evt_ready) begin
                        state <= IDLE; // event in FIFO
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // latch trigger and mask at acceptance
    always_ff @(posedge clk_ttc) begin
        if (state == IDLE && rec_valid) begin
            rec_q  <= rec;
            mask_q <= chan_en;
        end
    end

    // ---------------------------------------------------------
    // outputs
    // ---------------------------------------------------------

    assign rec_ready     = (state == IDLE);
    assign chan_trig     = (state == FIRE) ? mask_q : '0;
    assign chan_enable   = (state != IDLE) ? mask_q : '0; // until pushed
    assign evt_valid     = (state == PUSH);
    assign evt.rec       = rec_q;
    assign evt.chan_mask = mask_q;

endmodule

/* event_fifo.sv */
// single-clock FIFO with combinational head read; depth and threshold fixed by trig_macros.svh
`timescale 1ns/10ps
`include "trig_macros.svh"

module event_fifo (
    input  logic                 clk_ttc,
    input  logic                 rst_n,
    input  trig_pkg::acq_event_t push_data,
    input  logic                 push_valid,
    output logic                 push_ready,  // not full
    output trig_pkg::acq_event_t pop_data,    // head entry
    output logic                 pop_valid,   // not empty
    input  logic                 pop_ready,
    output logic                 almost_full
);
    import trig_pkg::*;

    localparam int ADDR_W = $clog2(`EVT_FIFO_DEPTH);
    localparam int CNT_W  = ADDR_W + 1;
    localparam logic [CNT_W-1:0] FULL_LVL  = CNT_W'(`EVT_FIFO_DEPTH);
    localparam logic [CNT_W-1:0] AFULL_LVL = CNT_W'(`EVT_FIFO_AFULL);

    acq_event_t        mem [`EVT_FIFO_DEPTH]; // event storage
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic [CNT_W-1:0]  count;                 // fill level
    logic              do_push;
    logic              do_pop;

    assign push_ready  = (count != FULL_LVL);
    assign pop_valid   = (count != '0);
    assign do_push     = push_valid && push_ready;
    assign do_pop      = pop_valid && pop_ready;
    assign pop_data    = mem[rd_ptr];
    assign almost_full = (count >= AFULL_LVL);

    // pointers wrap on their own
    always_ff @(posedge clk_ttc or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither
            endcase
        end
    end

    always_ff @(posedge clk_ttc) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

/* readout_requester.sv */
// one output register; an event with no channels becomes a request with the empty flag set
`timescale 1ns/10ps

module readout_requester (
    input  logic                   clk_ttc,
    input  logic                   rst_n,
    input  trig_pkg::acq_event_t   evt,           // FIFO head
    input  logic                   evt_valid,
    output logic                   evt_ready,     // FIFO pop
    output trig_pkg::readout_req_t req,           // to command manager
    output logic                   readout_valid,
    input  logic                   readout_ready  // command manager idle
);

    logic take_evt;

    // pop when the register is free or being drained this cycle
    assign evt_ready = !readout_valid || readout_ready;
    assign take_evt  = evt_valid && evt_ready;

    always_ff @(posedge clk_ttc or negedge rst_n) begin
        if (!rst_n) begin
            readout_valid <= 1'b0;
        end else begin
            if (take_evt) begin
                readout_valid <= 1'b1;
            end else if (readout_ready) begin
                readout_valid <= 1'b0; // drained with nothing behind it
            end
        end
    end

    // request payload
    always_ff @(posedge clk_ttc) begin
        if (take_evt) begin
            req.trig_num  <= evt.rec.trig_num;
            req.trig_type <= evt.rec.trig_type;
            req.timestamp <= evt.rec.timestamp;
            req.empty     <= (evt.chan_mask == '0); // no channel fired
        end
    end

endmodule

/* tb_trigger_top.sv */
// random run with fixed seed; a forced readout stall mid-run fills the FIFO and provokes rate errors
`timescale 1ns/10ps
`include "trig_macros.svh"

module tb_trigger_top;
    import trig_pkg::*;

    localparam int RUN_CYCLES  = 6000; // random traffic
    localparam int STALL_START = 2500; // readout blocked long enough to fill the FIFO
    localparam int STALL_LEN   = 700;
    localparam int DRAIN_LIMIT = 3000; // cycles allowed to empty the pipeline at the end

    logic         clk_ttc = 1'b0;
    logic         rst_n;
    logic         ttc_trigger;
    trig_type_t   trig_type;
    chan_mask_t   chan_en;
    chan_mask_t   chan_dones;
    chan_mask_t   chan_enable;
    chan_mask_t   chan_trig;
    readout_req_t req;
    logic         readout_valid;
    logic         readout_ready;
    logic         fifo_almost_full;
    logic         error_trig_rate;

    // ------------------------------------------------------------
    // reference model state after the last clock edge
    // ------------------------------------------------------------
    trig_ts_t     m_ts;       // timestamp counter
    trig_num_t    m_num;      // last accepted number
    logic         m_held;     // receiver holds a record
    trig_rec_t    m_rec;
    acq_state_t   m_st;       // controller phase
    chan_mask_t   m_mask;     // channels fired for current event
    chan_mask_t   m_pend;
    int           m_cnt;      // FIFO fill
    logic         m_rq_valid;
    logic         m_err;
    readout_req_t exp_q[$];   // requests still to come out
    int           done_cd [`TRIG_NUM_CHAN]; // channel model countdowns
    int           stall_left;
    bit           seen_afull;
    bit           seen_empty;
    int           n_req;

    always #2 clk_ttc = ~clk_ttc; // 4 ns period

    trigger_top dut0 (.*);

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_req(input readout_req_t got, input readout_req_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Error: req got %h expected %h", got, exp));
        end
    endtask

    task automatic check_mask(input string name, input chan_mask_t got, input chan_mask_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Error: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("Error: %s got %h expected %h", name, got, exp));
        end
    endtask

    // advance the model by one edge with the pre-edge inputs
    task automatic model_edge();
        logic         rx_go;
        logic         push_go;
        logic         pop_go;
        readout_req_t r;
        rx_go   = m_held && (m_st == IDLE);   // controller takes the record
        push_go = (m_st == PUSH) && (m_cnt < `EVT_FIFO_DEPTH);
        pop_go  = (m_cnt > 0) && (!m_rq_valid || readout_ready);
        case (m_st)
            IDLE: begin
                if (m_held) begin
                    r.trig_num  = m_rec.trig_num;
                    r.trig_type = m_rec.trig_type;
                    r.timestamp = m_rec.timestamp;
                    r.empty     = (chan_en == '0);  // mask as seen at acceptance
                    exp_q.push_back(r);
                    m_mask = chan_en;
                    m_st   = (chan_en == '0) ? PUSH : FIRE;
                end
            end
            FIRE: begin
                m_pend = m_mask;
                m_st   = WAIT_DONE;
            end
            WAIT_DONE: begin
                m_pend = m_pend & ~chan_dones;
                if (m_pend == '0) begin
                    m_st = PUSH;
                end
            end
            default: begin
                if (push_go) begin
                    m_st = IDLE;
                end
            end
        endcase
        // receiver holds one record
        if (ttc_trigger && !m_held) begin
            m_num           = m_num + 1'b1;
            m_rec.trig_num  = m_num;
            m_rec.trig_type = trig_type;
            m_rec.timestamp = m_ts;
            m_held          = 1'b1;
        end else begin
            if (ttc_trigger) begin
                m_err = 1'b1; // dropped trigger
            end
            if (rx_go) begin
                m_held = 1'b0;
            end
        end
        m_cnt = m_cnt + int'(push_go) - int'(pop_go);
        if (pop_go) begin
            m_rq_valid = 1'b1;
        end else if (readout_ready) begin
            m_rq_valid = 1'b0;
        end
        m_ts = m_ts + 1'b1;
    endtask

    task automatic drive_inputs(input int cyc);
        chan_mask_t dn;
        chan_mask_t busy;
        dn   = '0;
        busy = (m_st != IDLE) ? m_mask : '0;
        for (int c = 0; c < `TRIG_NUM_CHAN; c++) begin
            if (done_cd[c] > 0) begin
                done_cd[c]--;
                if (done_cd[c] == 0) begin
                    dn[c] = 1'b1;
                end
            end else if (!busy[c] && ($urandom % 8 == 0)) begin
                dn[c] = 1'b1; // stray done on an idle channel
            end
        end
        chan_dones  = dn;
        ttc_trigger = (cyc < RUN_CYCLES) && ($urandom % 5 == 0);
        trig_type   = trig_type_t'($urandom);
        chan_en     = ($urandom % 4 == 0) ? '0 : chan_mask_t'($urandom);
        if (cyc >= RUN_CYCLES) begin
            readout_ready = 1'b1; // drain
        end else if (cyc >= STALL_START && cyc < STALL_START + STALL_LEN) begin
            readout_ready = 1'b0;
        end else if (stall_left > 0) begin
            stall_left--;
            readout_ready = 1'b0;
        end else begin
            if ($urandom % 200 == 0) begin
                stall_left = 20 + int'($urandom % 150); // short random stall
            end
            readout_ready = ($urandom % 4 != 0);
        end
    endtask

    task automatic compare_outputs();
        check_mask("chan_trig", chan_trig, (m_st == FIRE) ? m_mask : '0);
        check_mask("chan_enable", chan_enable, (m_st != IDLE) ? m_mask : '0);
        check_flag("readout_valid", readout_valid, m_rq_valid);
        check_flag("fifo_almost_full", fifo_almost_full, m_cnt >= `EVT_FIFO_AFULL);
        check_flag("error_trig_rate", error_trig_rate, m_err);
        for (int c = 0; c < `TRIG_NUM_CHAN; c++) begin
            if (chan_trig[c]) begin
                done_cd[c] = 1 + int'($urandom % 20); // done 1 to 20 cycles later
            end
        end
        if (fifo_almost_full) begin
            seen_afull = 1'b1;
        end
        if (readout_valid && readout_ready) begin
            if (exp_q.size() == 0) begin
                fail_run("readout request came out with no accepted trigger behind it");
            end else begin
                check_req(req, exp_q.pop_front());
                n_req++;
                seen_empty = seen_empty || req.empty;
            end
        end
    endtask

    task run_cycle(input int cyc);
        @(posedge clk_ttc);
        model_edge();
        #1;
        drive_inputs(cyc);
        #2;
        compare_outputs(); // one ns before the next edge
    endtask

    initial begin
        int cyc;
        void'($urandom(32'hb6f9ea45));
        rst_n         = 1'b0;
        ttc_trigger   = 1'b0;
        trig_type     = '0;
        chan_en       = '0;
        chan_dones    = '0;
        readout_ready = 1'b0;
        m_ts          = '0;
        m_num         = '0;
        m_held        = 1'b0;
        m_rec         = '0;
        m_st          = IDLE;
        m_mask        = '0;
        m_pend        = '0;
        m_cnt         = 0;
        m_rq_valid    = 1'b0;
        m_err         = 1'b0;
        stall_left    = 0;
        seen_afull    = 1'b0;
        seen_empty    = 1'b0;
        n_req         = 0;
        foreach (done_cd[c]) begin
            done_cd[c] = 0;
        end
        repeat (3) @(posedge clk_ttc);
        #1 rst_n = 1'b1;
        #2 compare_outputs(); // reset values
        for (cyc = 0; cyc < RUN_CYCLES; cyc++) begin
            run_cycle(cyc);
        end
        // no more triggers and readout always ready
        while (exp_q.size() != 0 || m_held || m_st != IDLE || m_rq_valid || m_cnt != 0) begin
            if (cyc >= RUN_CYCLES + DRAIN_LIMIT) begin
                fail_run("timeout: pipeline did not drain after the last trigger");
            end else begin
                run_cycle(cyc);
                cyc++;
            end
        end
        if (!seen_afull || !seen_empty || !m_err) begin
            fail_run("almost-full, an empty event or a rate error was never exercised");
        end else begin
            $display("%0d readout requests checked", n_req);
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

/* trig_macros.svh */
// sizes for the trigger path; EVT_FIFO_DEPTH has to stay a power of two for pointer wrap
`ifndef TRIG_MACROS_SVH
`define TRIG_MACROS_SVH

// -----------------------------------------------------------
// channel fan-out
// -----------------------------------------------------------

// channel FPGAs driven by one trigger
`define TRIG_NUM_CHAN 5

// -----------------------------------------------------------
// trigger record fields
// -----------------------------------------------------------

`define TRIG_NUM_W  24 // global trigger number, first trigger is 1
`define TRIG_TS_W   44 // free-running ttc clock count
`define TRIG_TYPE_W 3  // muon fill, laser, pedestal ...

// -----------------------------------------------------------
// acquisition event FIFO
// -----------------------------------------------------------

`define EVT_FIFO_DEPTH 16 // entries
`define EVT_FIFO_AFULL 12 // fill level where almost-full goes high

`endif

/* trig_pkg.sv */
// types for the single-clock trigger path; all widths come from trig_macros.svh
`include "trig_macros.svh"

package trig_pkg;

    // plain vectors with a meaning
    typedef logic [`TRIG_NUM_W-1:0]    trig_num_t;  // trigger number
    typedef logic [`TRIG_TS_W-1:0]     trig_ts_t;   // timestamp in ttc clocks
    typedef logic [`TRIG_TYPE_W-1:0]   trig_type_t; // trigger type code
    typedef logic [`TRIG_NUM_CHAN-1:0] chan_mask_t; // one bit per channel

    // one accepted ttc trigger, receiver to controller
    typedef struct packed {
        trig_num_t  trig_num;
        trig_type_t trig_type;
        trig_ts_t   timestamp;
    } trig_rec_t;

    // finished acquisition, controller through FIFO to requester
    typedef struct packed {
        trig_rec_t  rec;       // trigger that started it
        chan_mask_t chan_mask; // channels that took part
    } acq_event_t;

    // request to the command manager
    typedef struct packed {
        trig_num_t  trig_num;
        trig_type_t trig_type;
        trig_ts_t   timestamp;
        logic       empty; // no channel acquired
    } readout_req_t;

    // channel acquisition controller
    typedef enum logic [1:0] {
        IDLE,      // waiting for a record
        FIRE,      // trigger pulse to channels
        WAIT_DONE, // collecting dones
        PUSH       // event offered to FIFO
    } acq_state_t;

endpackage

/* trigger_top.sv */
// single clock clk_ttc for every port; chan_en and chan_dones must already be in this domain
`timescale 1ns/10ps

module trigger_top (
    input  logic                   clk_ttc,          // ttc clock
    input  logic                   rst_n,
    input  logic                   ttc_trigger,      // ttc trigger strobe
    input  trig_pkg::trig_type_t   trig_type,
    input  trig_pkg::chan_mask_t   chan_en,          // enabled channels
    input  trig_pkg::chan_mask_t   chan_dones,
    output trig_pkg::chan_mask_t   chan_enable,
    output trig_pkg::chan_mask_t   chan_trig,
    output trig_pkg::readout_req_t req,              // readout request
    output logic                   readout_valid,
    input  logic                   readout_ready,
    output logic                   fifo_almost_full,
    output logic                   error_trig_rate
);
    import trig_pkg::*;

    // ---------------------------------------------------------
    // stage links
    // ---------------------------------------------------------

    trig_rec_t  rec;          // receiver to controller
    logic       rec_valid;
    logic       rec_ready;
    acq_event_t push_evt;     // controller to FIFO
    logic       push_valid;
    logic       push_ready;
    acq_event_t head_evt;     // FIFO to requester
    logic       pop_valid;
    logic       pop_ready;

    // ---------------------------------------------------------
    // pipeline
    // ---------------------------------------------------------

    ttc_trigger_receiver ttc_trigger_receiver (
        .clk_ttc         (clk_ttc),
        .rst_n           (rst_n),
        .ttc_trigger     (ttc_trigger),
        .trig_type       (trig_type),
        .rec             (rec),
        .rec_valid       (rec_valid),
        .rec_ready       (rec_ready),
        .error_trig_rate (error_trig_rate)
    );

    channel_acq_controller channel_acq_controller (
        .clk_ttc     (clk_ttc),
        .rst_n       (rst_n),
        .rec         (rec),
        .rec_valid   (rec_valid),
        .rec_ready   (rec_ready),
        .chan_en     (chan_en),
        .chan_dones  (chan_dones),
        .chan_enable (chan_enable),
        .chan_trig   (chan_trig),
        .evt         (push_evt),
        .evt_valid   (push_valid),
        .evt_ready   (push_ready)
    );

    // acquisition events waiting for readout
    event_fifo event_fifo (
        .clk_ttc     (clk_ttc),
        .rst_n       (rst_n),
        .push_data   (push_evt),
        .push_valid  (push_valid),
        .push_ready  (push_ready),
        .pop_data    (head_evt),
        .pop_valid   (pop_valid),
        .pop_ready   (pop_ready),
        .almost_full (fifo_almost_full)
    );

    readout_requester readout_requester (
        .clk_ttc       (clk_ttc),
        .rst_n         (rst_n),
        .evt           (head_evt),
        .evt_valid     (pop_valid),
        .evt_ready     (pop_ready),
        .req           (req),
        .readout_valid (readout_valid),
        .readout_ready (readout_ready)
    );

endmodule

/* ttc_trigger_receiver.sv */
// one record deep; a trigger arriving while it is valid is dropped and sets a sticky rate error
`timescale 1ns/10ps

module ttc_trigger_receiver (
    input  logic                   clk_ttc,         // ttc clock
    input  logic                   rst_n,
    input  logic                   ttc_trigger,     // one-cycle trigger strobe
    input  trig_pkg::trig_type_t   trig_type,       // sampled with the trigger
    output trig_pkg::trig_rec_t    rec,             // to acquisition controller
    output logic                   rec_valid,
    input  logic                   rec_ready,
    output logic                   error_trig_rate  // sticky until reset
);
    import trig_pkg::*;

    trig_ts_t  ts_cnt;   // free-running timestamp
    trig_num_t num_cnt;  // last accepted trigger number
    trig_num_t num_next;
    logic      take_trig;

    assign num_next  = num_cnt + 1'b1;
    assign take_trig = ttc_trigger && !rec_valid; // room only when nothing held

    // ---------------------------------------------------------
    // timestamp
    // ---------------------------------------------------------

    // zero in the first cycle out of reset
    always_ff @(posedge clk_ttc or negedge rst_n) begin
        if (!rst_n) begin
            ts_cnt <= '0;
        end else begin
            ts_cnt <= ts_cnt + 1'b1;
        end
    end

    // ---------------------------------------------------------
    // record handshake and counters
    // ---------------------------------------------------------

    always_ff @(posedge clk_ttc or negedge rst_n) begin
        if (!rst_n) begin
            rec_valid       <= 1'b0;
            num_cnt         <= '0;
            error_trig_rate <= 1'b0;
        end else begin
            if (rec_valid && rec_ready) begin
                rec_valid <= 1'b0; // handed to stage 2
            end
            if (take_trig) begin
                rec_valid <= 1'b1;
                num_cnt   <= num_next;
            end else if (ttc_trigger) begin
                error_trig_rate <= 1'b1; // dropped and number unchanged
            end
        end
    end

    // record payload
    always_ff @(posedge clk_ttc) begin
        if (take_trig) begin
            rec.trig_num  <= num_next;
            rec.trig_type <= trig_type;
            rec.timestamp <= ts_cnt; // counter value at the trigger edge
        end
    end

endmodule
